/* exec_stage.f */
+incdir+src
src/exec_op_pkg.sv
src/exec_word_pkg.sv
src/exec_alu.sv
src/exec_branch.sv
src/exec_mul.sv
src/exec_stage_reg.sv
src/exec_stage.sv
tb/tb_clkgen.sv
tb/exec_stage_chk.sv
tb/tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the execute stage testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f exec_stage.f --top-module tb_exec_stage -Mdir "$OBJ" -o sim_exec_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_exec_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* src/exec_alu.sv */
// ------------------------------------------------
// Integer ALU
// Arithmetic, logic and shift ops, compare flags
// and the raw sum for address generation
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "exec_consts.svh"

module exec_alu (
    input  exec_op_pkg::fu_e      i_fu,      // Unit owning the micro-op
    input  exec_word_pkg::uop_t   i_uop,     // Micro-op
    input  exec_word_pkg::xword_t i_lhs,     // Operand A
    input  exec_word_pkg::xword_t i_rhs,     // Operand B
    output exec_word_pkg::xword_t o_result,  // Selected ALU result
    output exec_word_pkg::xword_t o_sum,     // A + B, always
    output logic                  o_lt,      // A < B, signedness from op
    output logic                  o_eq       // A == B
);

    import exec_op_pkg::*;
    import exec_word_pkg::*;

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    logic               cmp_unsigned;        // Unsigned compare select
    logic [SHAMT_W-1:0] shamt;               // Shift amount
    xword_t             diff;                // A - B

    // ------------------------------------------------
    // Compare
    // ------------------------------------------------

    // Unsigned for sltu and the unsigned branches
    assign cmp_unsigned = (i_fu == FU_ALU && i_uop == ALU_SLTU) ||
                          (i_fu == FU_CFU && (i_uop == CFU_BLTU || i_uop == CFU_BGEU));

    assign o_lt = cmp_unsigned ? (i_lhs < i_rhs) :
                                 ($signed(i_lhs) < $signed(i_rhs));

    assign o_eq = (i_lhs == i_rhs);

    // ------------------------------------------------
    // Arithmetic and result select
    // ------------------------------------------------

    assign o_sum = i_lhs + i_rhs;            // Also feeds LSU and jalr
    assign diff  = i_lhs - i_rhs;
    assign shamt = i_rhs[SHAMT_W-1:0];       // Low bits only

    always_comb begin
        case (i_uop)
            ALU_ADD:  o_result = o_sum;
            ALU_SUB:  o_result = diff;
            ALU_XOR:  o_result = i_lhs ^ i_rhs;
            ALU_OR:   o_result = i_lhs | i_rhs;
            ALU_AND:  o_result = i_lhs & i_rhs;
            ALU_SLL:  o_result = i_lhs << shamt;
            ALU_SRL:  o_result = i_lhs >> shamt;
            ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;  // Sign fill
            ALU_SLT,
            ALU_SLTU: o_result = {{(`EXEC_XLEN-1){1'b0}}, o_lt};
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/exec_branch.sv */
// ------------------------------------------------
// Branch condition evaluation
// Jump and branch target alignment
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "exec_consts.svh"

module exec_branch (
    input  exec_word_pkg::uop_t   i_uop,     // CFU micro-op
    input  logic                  i_lt,      // Compare flags from the ALU
    input  logic                  i_eq,
    input  exec_word_pkg::xword_t i_sum,     // rs1 + imm for jalr
    input  exec_word_pkg::xword_t i_opr_c,   // Precomputed target
    output exec_word_pkg::uop_t   o_uop,     // Resolved micro-op
    output exec_word_pkg::xword_t o_target   // Target, bit 0 clear
);

    import exec_op_pkg::*;
    import exec_word_pkg::*;

    logic   is_cond;                         // Conditional branch
    logic   taken;
    xword_t base;                            // Target before alignment

    always_comb begin
        is_cond = 1'b1;
        case (i_uop)
            CFU_BEQ:            taken = i_eq;
            CFU_BNE:            taken = !i_eq;
            CFU_BLT, CFU_BLTU:  taken = i_lt;    // Flag already signed/unsigned
            CFU_BGE, CFU_BGEU:  taken = !i_lt;
            default: begin                       // Jumps keep their uop
                is_cond = 1'b0;
                taken   = 1'b0;
            end
        endcase
    end

    assign o_uop = !is_cond ? i_uop :
                   taken    ? uop_t'(CFU_TAKEN) : uop_t'(CFU_NOT_TAKEN);

    assign base     = (i_uop == CFU_JALR) ? i_sum : i_opr_c;
    assign o_target = {base[`EXEC_XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

/* src/exec_consts.svh */
// ------------------------------------------------
// Execute stage widths
// Data word, register address and micro-op fields
// ------------------------------------------------
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data word width
`define EXEC_XLEN  32

// Destination register address width
`define EXEC_RA_W  5

// Micro-op field width, shared by every unit
`define EXEC_UOP_W 5

`endif

/* src/exec_mul.sv */
// ------------------------------------------------
// Iterative unsigned shift-add multiplier
// One multiplier bit per cycle, product held until taken
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "exec_consts.svh"

module exec_mul (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   i_start,    // Request a multiply, used in IDLE
    input  logic                   i_take,     // Product consumed
    input  logic                   i_flush,    // Abandon and go IDLE
    input  exec_word_pkg::xword_t  i_a,        // Multiplicand
    input  exec_word_pkg::xword_t  i_b,        // Multiplier
    output logic                   o_done,     // Product valid
    output exec_word_pkg::dword_t  o_product   // Unsigned 2*XLEN product
);

    import exec_op_pkg::*;
    import exec_word_pkg::*;

    localparam int               CNT_W     = $clog2(`EXEC_XLEN);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EXEC_XLEN - 1);

    mul_state_e       state;
    logic [CNT_W-1:0] step;                    // Bit being processed
    dword_t           mcand;                   // Multiplicand, shifted left
    xword_t           mplier;                  // Remaining multiplier bits
    dword_t           acc;                     // Partial product

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            state <= ST_IDLE;
            step  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    step <= '0;
                    if (i_start) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) begin   // XLEN cycles in BUSY
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (i_take) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (state == ST_IDLE && i_start) begin
            mcand  <= dword_t'(i_a);           // Zero extend
            mplier <= i_b;
            acc    <= '0;
        end else if (state == ST_BUSY) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign o_done    = (state == ST_DONE);
    assign o_product = acc;

endmodule

`default_nettype wire

/* src/exec_op_pkg.sv */
// ------------------------------------------------
// Functional unit select and micro-op encodings
// Multiplier state encoding
// ------------------------------------------------
`default_nettype none
`include "exec_consts.svh"

package exec_op_pkg;

    // Functional unit select
    typedef enum logic [2:0] {
        FU_ALU = 3'd0, FU_CFU = 3'd1, FU_LSU = 3'd2,
        FU_MUL = 3'd3, FU_CSR = 3'd4
    } fu_e;

    // Integer ALU ops
    typedef enum logic [`EXEC_UOP_W-1:0] {
        ALU_ADD = 5'd0, ALU_SUB = 5'd1, ALU_XOR = 5'd2, ALU_OR   = 5'd3,
        ALU_AND = 5'd4, ALU_SLL = 5'd5, ALU_SRL = 5'd6, ALU_SRA  = 5'd7,
        ALU_SLT = 5'd8, ALU_SLTU = 5'd9
    } alu_op_e;

    // Control flow ops, top two bits give the class
    typedef enum logic [`EXEC_UOP_W-1:0] {
        CFU_BEQ  = 5'b00_001, CFU_BNE  = 5'b00_110, CFU_BLT = 5'b00_100,
        CFU_BGE  = 5'b00_010, CFU_BLTU = 5'b00_101, CFU_BGEU = 5'b00_011,
        CFU_JAL  = 5'b10_001, CFU_JALR = 5'b10_010,
        CFU_TAKEN = 5'b11_001, CFU_NOT_TAKEN = 5'b11_000 // Resolved branches
    } cfu_op_e;

    typedef enum logic [`EXEC_UOP_W-1:0] {
        LSU_LOAD = 5'd1, LSU_STORE = 5'd2
    } lsu_op_e;

    typedef enum logic [`EXEC_UOP_W-1:0] {
        MUL_MUL = 5'd0, MUL_MULHU = 5'd1   // Low word / high word
    } mul_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0, ST_BUSY = 2'd1, ST_DONE = 2'd2
    } mul_state_e;

endpackage

`default_nettype wire

/* src/exec_stage.sv */
// ------------------------------------------------
// Execute stage top level
// Request acceptance, unit selection, result muxing
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_flush,      // Flush stage contents
    input  exec_word_pkg::exec_req_t  i_req,        // Decoded request
    input  logic                      i_req_valid,
    output logic                      o_req_ready,
    output exec_word_pkg::exec_rsp_t  o_rsp,        // Result record
    output logic                      o_rsp_valid,
    input  logic                      i_rsp_ready
);

    import exec_op_pkg::*;
    import exec_word_pkg::*;

    logic      is_mul;                              // Request uses multiplier
    logic      accept;                              // Input transfer
    logic      mul_start;
    logic      mul_take;
    logic      mul_done;
    logic      reg_ready;                           // Output register has room
    logic      alu_lt;
    logic      alu_eq;
    xword_t    alu_result;
    xword_t    alu_sum;
    xword_t    cfu_target;
    uop_t      cfu_uop;
    dword_t    product;
    xword_t    prod_lo;
    xword_t    prod_hi;
    exec_rsp_t rsp;                                 // Next record

    // ------------------------------------------------
    // Handshake and multiplier strobes
    // ------------------------------------------------
    assign is_mul      = (i_req.fu == FU_MUL);
    assign o_req_ready = !i_flush && reg_ready && (!is_mul || mul_done);
    assign accept      = i_req_valid && o_req_ready;
    assign mul_start   = i_req_valid && is_mul && !i_flush;  // Acts only in IDLE
    assign mul_take    = accept && is_mul;

    assign {prod_hi, prod_lo} = product;

    // Result mux by unit
    always_comb begin
        rsp.rd     = i_req.rd;
        rsp.fu     = i_req.fu;
        rsp.uop    = i_req.uop;
        rsp.result = '0;
        rsp.opr_b  = '0;
        case (i_req.fu)
            FU_ALU: rsp.result = alu_result;
            FU_CFU: begin
                rsp.result = cfu_target;
                rsp.uop    = cfu_uop;               // TAKEN / NOT_TAKEN
            end
            FU_LSU: begin
                rsp.result = alu_sum;               // Effective address
                if (i_req.uop == LSU_STORE) begin
                    rsp.opr_b = i_req.opr_c;        // Store data
                end
            end
            FU_CSR: begin
                rsp.result = i_req.opr_a;
                rsp.opr_b  = i_req.opr_c;
            end
            FU_MUL: begin
                rsp.result = (i_req.uop == MUL_MULHU) ? prod_hi : prod_lo;
                rsp.opr_b  = prod_hi;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------
    // Units and output register
    // ------------------------------------------------
    exec_alu u_alu (
        .i_fu      (i_req.fu   ),
        .i_uop     (i_req.uop  ),
        .i_lhs     (i_req.opr_a),
        .i_rhs     (i_req.opr_b),
        .o_result  (alu_result ),
        .o_sum     (alu_sum    ),
        .o_lt      (alu_lt     ),
        .o_eq      (alu_eq     )
    );

    exec_branch u_branch (
        .i_uop     (i_req.uop  ),
        .i_lt      (alu_lt     ),
        .i_eq      (alu_eq     ),
        .i_sum     (alu_sum    ),
        .i_opr_c   (i_req.opr_c),
        .o_uop     (cfu_uop    ),
        .o_target  (cfu_target )
    );

    exec_mul u_mul (
        .g_clk     (g_clk      ),
        .g_resetn  (g_resetn   ),
        .i_start   (mul_start  ),
        .i_take    (mul_take   ),
        .i_flush   (i_flush    ),
        .i_a       (i_req.opr_a),
        .i_b       (i_req.opr_b),
        .o_done    (mul_done   ),
        .o_product (product    )
    );

    exec_stage_reg u_out_reg (
        .g_clk      (g_clk      ),
        .g_resetn   (g_resetn   ),
        .i_flush    (i_flush    ),
        .i_valid    (accept     ),
        .i_data     (rsp        ),
        .o_in_ready (reg_ready  ),
        .o_valid    (o_rsp_valid),
        .o_data     (o_rsp      ),
        .i_ready    (i_rsp_ready)
    );

endmodule

`default_nettype wire

/* src/exec_stage_reg.sv */
// ------------------------------------------------
// One-entry valid/ready output register with flush
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_stage_reg (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_flush,     // Drop the held record
    input  logic                      i_valid,     // Load request
    input  exec_word_pkg::exec_rsp_t  i_data,
    output logic                      o_in_ready,  // Can take a record this cycle
    output logic                      o_valid,
    output exec_word_pkg::exec_rsp_t  o_data,
    input  logic                      i_ready      // Downstream accepts
);

    logic load;                                    // Record enters this edge

    // Empty, or the held record leaves this cycle
    assign o_in_ready = !o_valid || i_ready;
    assign load       = i_valid && o_in_ready && !i_flush;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;                       // Drained, nothing new
        end
    end

    always_ff @(posedge g_clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

endmodule

`default_nettype wire

/* src/exec_word_pkg.sv */
// ------------------------------------------------
// Data word types, request and result records
// ------------------------------------------------
`default_nettype none
`include "exec_consts.svh"

package exec_word_pkg;

    import exec_op_pkg::*;

    typedef logic [`EXEC_XLEN-1:0]   xword_t;    // One data word
    typedef logic [2*`EXEC_XLEN-1:0] dword_t;    // Full product
    typedef logic [`EXEC_RA_W-1:0]   reg_addr_t; // Destination register
    typedef logic [`EXEC_UOP_W-1:0]  uop_t;      // Raw micro-op, meaning set by fu

    // Decoded request into the stage
    typedef struct packed {
        reg_addr_t rd;
        fu_e       fu;
        uop_t      uop;
        xword_t    opr_a;
        xword_t    opr_b;
        xword_t    opr_c;       // Store data, CSR data or jump target
    } exec_req_t;

    // Result record to the next stage
    typedef struct packed {
        reg_addr_t rd;
        fu_e       fu;
        uop_t      uop;         // Resolved for branches
        xword_t    result;
        xword_t    opr_b;
    } exec_rsp_t;

endpackage

`default_nettype wire

/* tb/exec_stage_chk.sv */
// ------------------------------------------------
// Concurrent assertions on the execute stage ports
// Output hold, flush blocking and empty after reset
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_stage_chk (
    input logic                     g_clk,
    input logic                     g_resetn,
    input logic                     i_flush,
    input logic                     o_req_ready,
    input exec_word_pkg::exec_rsp_t o_rsp,
    input logic                     o_rsp_valid,
    input logic                     i_rsp_ready
);

    int assert_fails = 0;                      // Failed assertion count

    // Held record must not change under back-pressure
    a_rsp_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_rsp_valid && !i_rsp_ready) |=> $stable(o_rsp))
        else begin
            assert_fails++;
            $error("o_rsp changed while stalled");
        end

    a_flush_ready: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_flush |-> !o_req_ready)
        else begin
            assert_fails++;
            $error("o_req_ready high during flush");
        end

    a_reset_empty: assert property (@(posedge g_clk)
        !g_resetn |=> !o_rsp_valid)
        else begin
            assert_fails++;
            $error("o_rsp_valid high after reset");
        end

    a_flush_empty: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_flush |=> !o_rsp_valid)
        else begin
            assert_fails++;
            $error("o_rsp_valid high after flush");
        end

endmodule

bind exec_stage exec_stage_chk u_chk (
    .g_clk       (g_clk      ),
    .g_resetn    (g_resetn   ),
    .i_flush     (i_flush    ),
    .o_req_ready (o_req_ready),
    .o_rsp       (o_rsp      ),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready)
);

`default_nettype wire

/* tb/tb_clkgen.sv */
// ------------------------------------------------
// Testbench clock and reset generator
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 40,           // Clock period
    parameter int RESET_CYCLES = 4             // Cycles with reset low
) (
    output logic o_clk,
    output logic o_resetn
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);                      // Release away from the active edge
        o_resetn = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_exec_stage.sv */
// ------------------------------------------------
// Execute stage testbench
// Directed tests, reference model, compare tasks,
// response monitor, watchdog and summary
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "exec_consts.svh"

module tb_exec_stage;

    import exec_op_pkg::*;
    import exec_word_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int ALU_ROUNDS = 3;             // Passes over all ten ALU ops
    localparam int LSU_ROUNDS = 4;
    localparam int MUL_COUNT  = 16;
    localparam int MIX_COUNT  = 40;
    localparam int N_SIMPLE   = 10 * ALU_ROUNDS + 34 + 3 * LSU_ROUNDS + 2;
    localparam int N_MULT     = MUL_COUNT + MIX_COUNT + 2;   // Mixed counted as worst case
    localparam int WD_CYCLES  = 2 * (N_SIMPLE * 6 + N_MULT * (`EXEC_XLEN + 8)) + 100;

    logic      g_clk;
    logic      g_resetn;
    exec_req_t req        = '0;
    logic      req_valid  = 1'b0;
    logic      req_ready;
    exec_rsp_t rsp;
    logic      rsp_valid;
    logic      rsp_ready  = 1'b1;
    logic      flush      = 1'b0;
    int        seed       = 64;
    int        ready_mode = 0;                 // 0 ready, 1 random, 2 stalled
    int        err_cnt    = 0;
    int        pass_cnt   = 0;
    int        fail_cnt   = 0;
    exec_rsp_t exp_q [$];                      // Expected records in order

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clkgen (
        .o_clk    (g_clk   ),
        .o_resetn (g_resetn)
    );

    exec_stage u_exec_stage (
        .g_clk       (g_clk    ),
        .g_resetn    (g_resetn ),
        .i_flush     (flush    ),
        .i_req       (req      ),
        .i_req_valid (req_valid),
        .o_req_ready (req_ready),
        .o_rsp       (rsp      ),
        .o_rsp_valid (rsp_valid),
        .i_rsp_ready (rsp_ready)
    );

    // ------------------------------------------------
    // Compare tasks
    // ------------------------------------------------
    task automatic check_word(input string name, input xword_t exp, input xword_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_uop(input string name, input uop_t exp, input uop_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_fu(input string name, input fu_e exp, input fu_e act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------
    function automatic xword_t alu_model(input uop_t op, input xword_t a, input xword_t b);
        int sh;
        sh = int'(b % `EXEC_XLEN);             // Low shift bits only
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $signed(a) >>> sh;
            ALU_SLT:  return xword_t'($signed(a) < $signed(b));
            ALU_SLTU: return xword_t'(a < b);
            default:  return '0;
        endcase
    endfunction

    function automatic exec_rsp_t model_rsp(input exec_req_t r);
        exec_rsp_t e;
        dword_t    prod;
        xword_t    sum;
        logic      take;
        e.rd     = r.rd;
        e.fu     = r.fu;
        e.uop    = r.uop;
        e.result = '0;
        e.opr_b  = '0;
        sum      = r.opr_a + r.opr_b;
        prod     = dword_t'(r.opr_a) * dword_t'(r.opr_b);   // Unsigned full product
        case (r.uop)
            CFU_BEQ:  take = (r.opr_a == r.opr_b);
            CFU_BNE:  take = (r.opr_a != r.opr_b);
            CFU_BLT:  take = ($signed(r.opr_a) < $signed(r.opr_b));
            CFU_BGE:  take = ($signed(r.opr_a) >= $signed(r.opr_b));
            CFU_BLTU: take = (r.opr_a < r.opr_b);
            CFU_BGEU: take = (r.opr_a >= r.opr_b);
            default:  take = 1'b0;
        endcase
        case (r.fu)
            FU_ALU: e.result = alu_model(r.uop, r.opr_a, r.opr_b);
            FU_CFU: begin
                e.result = (r.uop == CFU_JALR) ? sum : r.opr_c;
                e.result[0] = 1'b0;            // Aligned target
                if (r.uop != CFU_JAL && r.uop != CFU_JALR) begin
                    e.uop = take ? CFU_TAKEN : CFU_NOT_TAKEN;
                end
            end
            FU_LSU: begin
                e.result = sum;                // Effective address
                if (r.uop == LSU_STORE) begin
                    e.opr_b = r.opr_c;
                end
            end
            FU_CSR: begin
                e.result = r.opr_a;
                e.opr_b  = r.opr_c;
            end
            FU_MUL: begin
                e.opr_b  = prod[2*`EXEC_XLEN-1:`EXEC_XLEN];
                e.result = (r.uop == MUL_MULHU) ? e.opr_b : prod[`EXEC_XLEN-1:0];
            end
            default: ;
        endcase
        return e;
    endfunction

    // ------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------
    function automatic xword_t rand_word();
        return xword_t'($random(seed));
    endfunction

    function automatic exec_req_t make_req(input fu_e fu, input uop_t uop,
                                           input xword_t a, input xword_t b, input xword_t c);
        exec_req_t r;
        r.rd    = reg_addr_t'($random(seed));
        r.fu    = fu;
        r.uop   = uop;
        r.opr_a = a;
        r.opr_b = b;
        r.opr_c = c;
        return r;
    endfunction

    function automatic uop_t cfu_pick(input int k);
        case (k)
            0:       return CFU_BEQ;
            1:       return CFU_BNE;
            2:       return CFU_BLT;
            3:       return CFU_BGE;
            4:       return CFU_BLTU;
            5:       return CFU_BGEU;
            6:       return CFU_JAL;
            default: return CFU_JALR;
        endcase
    endfunction

    function automatic exec_req_t random_req();
        fu_e  fu;
        uop_t uop;
        fu = fu_e'($unsigned($random(seed)) % 5);
        case (fu)
            FU_ALU:  uop = uop_t'($unsigned($random(seed)) % 10);
            FU_CFU:  uop = cfu_pick($unsigned($random(seed)) % 8);
            FU_LSU:  uop = (($random(seed) & 1) != 0) ? LSU_STORE : LSU_LOAD;
            FU_MUL:  uop = (($random(seed) & 1) != 0) ? MUL_MULHU : MUL_MUL;
            default: uop = '0;
        endcase
        return make_req(fu, uop, rand_word(), rand_word(), rand_word());
    endfunction

    // Present one request and wait for its transfer edge
    task automatic send_req(input exec_req_t r);
        @(negedge g_clk);
        req       = r;
        req_valid = 1'b1;
        #1;
        while (!req_ready) begin
            @(negedge g_clk);
            #1;
        end
        exp_q.push_back(model_rsp(r));
        @(posedge g_clk);
    endtask

    // Drop valid and wait until every expected record has arrived
    task automatic drain();
        @(negedge g_clk);
        req_valid = 1'b0;
        #2;
        while (exp_q.size() != 0) begin
            @(negedge g_clk);
            #2;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
            pass_cnt++;
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    // Output side: ready pattern on the falling edge, then check any transfer
    always @(negedge g_clk) begin
        case (ready_mode)
            0:       rsp_ready = 1'b1;
            1:       rsp_ready = (($random(seed) & 1) != 0);
            default: rsp_ready = 1'b0;
        endcase
        #1;
        if (g_resetn && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected response at %0t with no request outstanding", $time);
                err_cnt++;
            end else begin
                check_rd("o_rsp.rd", exp_q[0].rd, rsp.rd);
                check_fu("o_rsp.fu", exp_q[0].fu, rsp.fu);
                check_uop("o_rsp.uop", exp_q[0].uop, rsp.uop);
                check_word("o_rsp.result", exp_q[0].result, rsp.result);
                check_word("o_rsp.opr_b", exp_q[0].opr_b, rsp.opr_b);
                void'(exp_q.pop_front());
            end
        end
    end

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic test_alu();
        int errs;
        errs = err_cnt;
        for (int n = 0; n < ALU_ROUNDS; n++) begin
            for (int op = 0; op < 10; op++) begin
                send_req(make_req(FU_ALU, uop_t'(op), rand_word(), rand_word(), rand_word()));
            end
        end
        drain();
        end_test("alu", errs);
    endtask

    task automatic test_branch();
        xword_t lhs [5];
        xword_t rhs [5];
        xword_t v;
        int     errs;
        errs   = err_cnt;
        v      = rand_word();
        lhs[0] = v;                            // Equal
        rhs[0] = v;
        lhs[1] = v | 32'h8000_0000;            // Signed less, unsigned greater
        rhs[1] = v & 32'h7fff_ffff;
        lhs[2] = rhs[1];                       // Signed greater, unsigned less
        rhs[2] = lhs[1];
        lhs[3] = 32'd2;                        // Less in both senses
        rhs[3] = 32'd9;
        lhs[4] = 32'd9;
        rhs[4] = 32'd2;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 5; p++) begin
                send_req(make_req(FU_CFU, cfu_pick(k), lhs[p], rhs[p], rand_word()));
            end
        end
        for (int n = 0; n < 2; n++) begin      // Odd target bases
            send_req(make_req(FU_CFU, CFU_JAL, rand_word(), rand_word(), rand_word() | 32'd1));
            send_req(make_req(FU_CFU, CFU_JALR, rand_word() | 32'd1,
                              rand_word() & ~32'd1, rand_word()));
        end
        drain();
        end_test("branch", errs);
    endtask

    task automatic test_lsu_csr();
        int errs;
        errs = err_cnt;
        for (int n = 0; n < LSU_ROUNDS; n++) begin
            send_req(make_req(FU_LSU, LSU_LOAD, rand_word(), rand_word(), rand_word()));
            send_req(make_req(FU_LSU, LSU_STORE, rand_word(), rand_word(), rand_word()));
            send_req(make_req(FU_CSR, '0, rand_word(), rand_word(), rand_word()));
        end
        drain();
        end_test("lsu_csr", errs);
    endtask

    task automatic test_mul();
        int errs;
        errs = err_cnt;
        send_req(make_req(FU_MUL, MUL_MULHU, '1, '1, '0));   // Largest product
        for (int n = 1; n < MUL_COUNT; n++) begin
            send_req(make_req(FU_MUL, (n % 2 != 0) ? MUL_MULHU : MUL_MUL,
                              rand_word(), rand_word(), rand_word()));
        end
        drain();
        end_test("mul", errs);
    endtask

    task automatic test_mixed();
        int errs;
        errs       = err_cnt;
        ready_mode = 1;                        // Random back-pressure
        for (int n = 0; n < MIX_COUNT; n++) begin
            send_req(random_req());
        end
        drain();
        ready_mode = 0;
        end_test("mixed", errs);
    endtask

    task automatic test_flush();
        int errs;
        errs       = err_cnt;
        ready_mode = 2;                        // Hold the first record
        send_req(make_req(FU_ALU, ALU_ADD, rand_word(), rand_word(), rand_word()));
        @(negedge g_clk);
        req       = make_req(FU_MUL, MUL_MUL, rand_word(), rand_word(), rand_word());
        req_valid = 1'b1;
        repeat (8) @(negedge g_clk);           // Multiplier now in BUSY
        flush = 1'b1;                          // Drops held record and multiply
        @(negedge g_clk);
        req = make_req(FU_ALU, ALU_OR, rand_word(), rand_word(), rand_word());
        #1;                                    // Register empty, only flush blocks it
        if (rsp_valid) begin
            $display("Response still valid at %0t after flush", $time);
            err_cnt++;
        end
        if (req_ready) begin
            $display("Request accepted at %0t while flush was high", $time);
            err_cnt++;
        end
        @(negedge g_clk);
        flush     = 1'b0;
        req_valid = 1'b0;
        #1;
        exp_q.delete();                        // Flushed record must never show up
        ready_mode = 0;
        send_req(make_req(FU_MUL, MUL_MULHU, rand_word(), rand_word(), rand_word()));
        send_req(make_req(FU_ALU, ALU_XOR, rand_word(), rand_word(), rand_word()));
        drain();
        end_test("flush", errs);
    endtask

    // ------------------------------------------------
    // Sequence, summary and watchdog
    // ------------------------------------------------
    initial begin
        wait (g_resetn);
        test_alu();
        test_branch();
        test_lsu_csr();
        test_mul();
        test_mixed();
        test_flush();
        $display("summary: %0d tests ok, %0d tests with errors, %0d assertion failures",
                 pass_cnt, fail_cnt, u_exec_stage.u_chk.assert_fails);
        if (fail_cnt == 0 && err_cnt == 0 && u_exec_stage.u_chk.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, run did not finish within %0d cycles", WD_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
